// ==== design/aes_ctr_cfg.svh ====
// Build-time sizes of the AES-CTR counter block
// Included by the package and by every RTL module that sizes a port or a slice
// The slice count is derived, so only the width and slice size are tuned here

`ifndef AES_CTR_CFG_SVH
`define AES_CTR_CFG_SVH

// Full counter block, one AES block wide
`define AES_CTR_WIDTH 128

// Bits added per clock cycle by the increment FSM
`define AES_CTR_SLICE_SIZE 16

// Number of slices walked per increment
// Counter width must be a multiple of the slice size
`define AES_CTR_NUM_SLICES (`AES_CTR_WIDTH / `AES_CTR_SLICE_SIZE)

`endif

// ==== design/aes_ctr_pkg.sv ====
// Shared types for the AES-CTR counter datapath
// Holds the FSM state encoding, the multi-rail request code and the slice index width
// Imported by wildcard in the header of each RTL module

`include "aes_ctr_cfg.svh"

package aes_ctr_pkg;

  // Bits needed to address one slice of the counter block
  localparam int unsigned slice_idx_w = $clog2(`AES_CTR_NUM_SLICES);

  ////////////////////////////////////////////////////////////////////////////
  // Counter FSM states
  ////////////////////////////////////////////////////////////////////////////

  // 5-bit codes, pairwise Hamming distance of at least 3
  // A single flipped state bit never lands on another valid state
  typedef enum logic [4:0] {
    CTR_IDLE  = 5'b01110,
    CTR_INCR  = 5'b11000,
    CTR_ERROR = 5'b00001
  } aes_ctr_e;

  ////////////////////////////////////////////////////////////////////////////
  // Multi-rail request code
  ////////////////////////////////////////////////////////////////////////////

  // Complementary rails, alternating bit pattern
  // Any of the other 14 values is a fault
  typedef enum logic [3:0] {
    MUBI4_TRUE  = 4'hA,
    MUBI4_FALSE = 4'h5
  } mubi4_e;

endpackage

// ==== design/aes_ctr_mr_check.sv ====
// Multi-rail decoder for the counter increment request
// Turns the 4-bit code into a single-bit strobe for the FSM
// and flags any code that is neither true nor false as a fault

module aes_ctr_mr_check import aes_ctr_pkg::*; (
  // Only used by the assertion below
  input  logic   clk_i,
  input  logic   rst_ni,

  // Request code from the requester
  input  mubi4_e incr_mr_i,

  // Decoded increment strobe
  output logic   incr_o,
  // Code is not a legal multi-rail value
  output logic   mr_err_o
);

  // Code classification
  logic is_true;
  logic is_false;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  // Exact compare on all four rails
  // 4'hA -> request, 4'h5 -> no request
  assign is_true  = (incr_mr_i == MUBI4_TRUE);
  assign is_false = (incr_mr_i == MUBI4_FALSE);

  // Strobe only on a clean true code
  // Faulty codes never look like a request
  assign incr_o = is_true;

  // Everything else is an error
  // Includes all-zero and all-one rails, the typical stuck-at patterns
  assign mr_err_o = ~(is_true | is_false);

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // A faulty code must never also be taken as a request
  // Otherwise the FSM would start an increment in the same cycle it errors out
  incr_err_exclusive_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(incr_o && mr_err_o)
  ) else $error("incr_o and mr_err_o high together, code %h", incr_mr_i);

endmodule

// ==== design/aes_ctr_fsm.sv ====
// Slice-serial increment FSM for the AES-CTR counter block
// Walks the counter one slice per cycle from low to high, rippling the carry
// through a one-bit register; any fault input locks it in a terminal error state
// with a sticky alert that only reset clears

`include "aes_ctr_cfg.svh"

module aes_ctr_fsm import aes_ctr_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // Request and status
  input  logic                           incr_i,
  output logic                           ready_o,
  input  logic                           incr_err_i,
  input  logic                           mr_err_i,
  output logic                           alert_o,

  // Slice access to the counter register
  output logic [slice_idx_w-1:0]         ctr_slice_idx_o,
  input  logic [`AES_CTR_SLICE_SIZE-1:0] ctr_slice_i,
  output logic [`AES_CTR_SLICE_SIZE-1:0] ctr_slice_o,
  output logic                           ctr_we_o
);

  localparam int unsigned slice_w = `AES_CTR_SLICE_SIZE;

  // Index of the last slice, end of the walk
  localparam logic [slice_idx_w-1:0] last_idx = slice_idx_w'(`AES_CTR_NUM_SLICES - 1);

  // State
  aes_ctr_e               aes_ctr_ns;
  aes_ctr_e               aes_ctr_cs;

  // Walk position and carry into the current slice
  logic [slice_idx_w-1:0] slice_idx_d;
  logic [slice_idx_w-1:0] slice_idx_q;
  logic                   carry_d;
  logic                   carry_q;

  // Slice plus carry, one bit wider for the carry out
  logic [slice_w:0]       ctr_value;

  ////////////////////////////////////////////////////////////////////////////
  // Slice adder
  ////////////////////////////////////////////////////////////////////////////

  // Zero-extend both operands so the carry out lands in the top bit
  assign ctr_value = {1'b0, ctr_slice_i} + {{slice_w{1'b0}}, carry_q};

  // Low bits go back to the register
  assign ctr_slice_o = ctr_value[slice_w-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : fsm_comb
    // Outputs default to inactive
    ready_o  = 1'b0;
    ctr_we_o = 1'b0;
    alert_o  = 1'b0;

    // Hold by default
    aes_ctr_ns  = aes_ctr_cs;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;

    unique case (aes_ctr_cs)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at the lowest slice, adding one
          slice_idx_d = '0;
          carry_d     = 1'b1;
          aes_ctr_ns  = CTR_INCR;
        end
      end

      CTR_INCR: begin
        // Write this slice, move up, keep the carry out
        ctr_we_o    = 1'b1;
        slice_idx_d = slice_idx_q + slice_idx_w'(1);
        carry_d     = ctr_value[slice_w];

        // Top slice written this cycle, done
        // Carry out of the top slice is dropped, giving the wrap to zero
        if (slice_idx_q == last_idx) begin
          aes_ctr_ns = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal, no way out except reset
        alert_o = 1'b1;
      end

      // Illegal encoding, e.g. after a glitch on the state flops
      default: begin
        alert_o    = 1'b1;
        aes_ctr_ns = CTR_ERROR;
      end
    endcase

    // Faults override any transition taken above
    if (incr_err_i || mr_err_i) begin
      aes_ctr_ns = CTR_ERROR;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aes_ctr_cs  <= CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      aes_ctr_cs  <= aes_ctr_ns;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  // Register addresses the slice being worked on
  assign ctr_slice_idx_o = slice_idx_q;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Any state outside idle and increment must show up as an alert
  state_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !alert_o |-> aes_ctr_cs inside {CTR_IDLE, CTR_INCR}
  ) else $error("no alert but state is %b", aes_ctr_cs);

  // Slice writes only happen during the walk
  we_in_incr_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ctr_we_o |-> aes_ctr_cs == CTR_INCR
  ) else $error("ctr_we_o high in state %b", aes_ctr_cs);

  // Alert is sticky until reset
  alert_sticky_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o
  ) else $error("alert_o dropped without reset");

endmodule

// ==== design/aes_ctr_reg.sv ====
// Storage for the 128-bit counter block, kept as separate slices
// Full-width load from outside while the FSM is idle; single-slice
// write and combinational read for the increment FSM

`include "aes_ctr_cfg.svh"

module aes_ctr_reg import aes_ctr_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // External load, honoured only while the FSM is ready
  input  logic                           load_i,
  input  logic                           ready_i,
  input  logic [`AES_CTR_WIDTH-1:0]      ctr_data_i,

  // Slice port from the FSM
  input  logic [slice_idx_w-1:0]         slice_idx_i,
  input  logic [`AES_CTR_SLICE_SIZE-1:0] slice_wdata_i,
  input  logic                           we_i,
  output logic [`AES_CTR_SLICE_SIZE-1:0] slice_rdata_o,

  // Whole block
  output logic [`AES_CTR_WIDTH-1:0]      ctr_o
);

  localparam int unsigned slice_w    = `AES_CTR_SLICE_SIZE;
  localparam int unsigned num_slices = `AES_CTR_NUM_SLICES;

  // Slice 0 holds the least significant bits
  logic [slice_w-1:0] slice_q [num_slices];

  // Gated load
  logic               load_en;

  assign load_en = load_i & ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Slice registers
  ////////////////////////////////////////////////////////////////////////////

  // Counter comes out of reset as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < num_slices; i++) begin
        slice_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_slices; i++) begin
        if (load_en) begin
          // Whole block replaced
          slice_q[i] <= ctr_data_i[i*slice_w +: slice_w];
        end else if (we_i && (slice_idx_i == slice_idx_w'(i))) begin
          // Only the addressed slice
          slice_q[i] <= slice_wdata_i;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////////////

  // Current slice for the FSM adder, no latency
  assign slice_rdata_o = slice_q[slice_idx_i];

  // Repack the slices into the flat block
  always_comb begin
    for (int i = 0; i < num_slices; i++) begin
      ctr_o[i*slice_w +: slice_w] = slice_q[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // FSM only writes while busy, so a load must never be accepted then
  load_write_excl_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !load_en
  ) else $error("load and slice write in the same cycle, slice %0d", slice_idx_i);

endmodule

// ==== design/aes_ctr_top.sv ====
// Top level of the AES-CTR counter increment block
// Connects the multi-rail request checker, the slice-serial increment FSM
// and the counter storage; ready_o tells the requester when an increment
// or a load will be taken

`include "aes_ctr_cfg.svh"

module aes_ctr_top import aes_ctr_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Increment request and external fault
  input  mubi4_e                    incr_mr_i,
  input  logic                      incr_err_i,

  // Counter load
  input  logic                      load_i,
  input  logic [`AES_CTR_WIDTH-1:0] ctr_data_i,

  // Status and result
  output logic                      ready_o,
  output logic [`AES_CTR_WIDTH-1:0] ctr_o,
  output logic                      alert_o
);

  // Checker to FSM
  logic                           incr;
  logic                           mr_err;

  // FSM to register and back
  logic [slice_idx_w-1:0]         ctr_slice_idx;
  logic [`AES_CTR_SLICE_SIZE-1:0] ctr_slice_wdata;
  logic [`AES_CTR_SLICE_SIZE-1:0] ctr_slice_rdata;
  logic                           ctr_we;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////////////

  aes_ctr_mr_check mr_check_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .incr_mr_i (incr_mr_i),
    .incr_o    (incr),
    .mr_err_o  (mr_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Increment control
  ////////////////////////////////////////////////////////////////////////////

  aes_ctr_fsm fsm_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .incr_i          (incr),
    .ready_o         (ready_o),
    .incr_err_i      (incr_err_i),
    .mr_err_i        (mr_err),
    .alert_o         (alert_o),
    .ctr_slice_idx_o (ctr_slice_idx),
    .ctr_slice_i     (ctr_slice_rdata),
    .ctr_slice_o     (ctr_slice_wdata),
    .ctr_we_o        (ctr_we)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Counter storage
  ////////////////////////////////////////////////////////////////////////////

  // Same ready level gates external loads
  aes_ctr_reg reg_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .load_i        (load_i),
    .ready_i       (ready_o),
    .ctr_data_i    (ctr_data_i),
    .slice_idx_i   (ctr_slice_idx),
    .slice_wdata_i (ctr_slice_wdata),
    .we_i          (ctr_we),
    .slice_rdata_o (ctr_slice_rdata),
    .ctr_o         (ctr_o)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
// Clock and reset source for the counter testbench
// Free-running clock plus an active-low reset held for a fixed number of cycles,
// applied at power-on and again on each rising edge of rst_req_i

module tb_clk_gen #(
  parameter int period_ns  = 100,
  parameter int rst_cycles = 8,
  parameter int drive_ns   = 10
) (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  // Hold reset low, release just after an edge like any other input
  task automatic apply_reset();
    rst_no = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    #(drive_ns) rst_no = 1'b1;
  endtask

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Power-on reset first, then one reset per request
  initial begin
    apply_reset();
    forever begin
      @(posedge rst_req_i);
      @(posedge clk_o);
      #(drive_ns);
      apply_reset();
    end
  end

endmodule

// ==== test/tb_aes_ctr_top.sv ====
// Testbench for the AES-CTR counter increment block
// Drives loads, increments and faults into the DUT; concurrent assertions
// compare ctr_o, ready_o and alert_o against a plus-one reference model

`include "aes_ctr_cfg.svh"

module tb_aes_ctr_top import aes_ctr_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int period_ns  = 100;
  localparam int rst_cycles = 8;
  localparam int drive_ns   = 10;
  localparam int num_tests  = 6;
  // Busy time is 8 cycles so 20 leaves a wide margin before a hang is declared
  localparam int ready_wait = 20;

  // DUT connections
  logic                      clk;
  logic                      rst_n;
  logic                      rst_req;
  mubi4_e                    incr_mr;
  logic                      incr_err;
  logic                      load;
  logic [`AES_CTR_WIDTH-1:0] ctr_data;
  logic                      ready;
  logic [`AES_CTR_WIDTH-1:0] ctr;
  logic                      alert;

  // Reference model and bookkeeping
  logic [`AES_CTR_WIDTH-1:0] model_ctr;
  logic [`AES_CTR_WIDTH-1:0] exp_ctr;
  int                        seed = 63516;
  int                        err_cnt = 0;
  int                        pass_cnt = 0;
  int                        fail_cnt = 0;

  tb_clk_gen #(
    .period_ns  (period_ns),
    .rst_cycles (rst_cycles),
    .drive_ns   (drive_ns)
  ) clk_gen_inst (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_no    (rst_n)
  );

  aes_ctr_top aes_ctr_top_inst (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .incr_mr_i  (incr_mr),
    .incr_err_i (incr_err),
    .load_i     (load),
    .ctr_data_i (ctr_data),
    .ready_o    (ready),
    .ctr_o      (ctr),
    .alert_o    (alert)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic log_mismatch(string sig, logic [127:0] exp_v, logic [127:0] act_v);
    $display("[ERROR] %0t %s expected %0h actual %0h", $time, sig, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic log_failure(string what);
    $display("%0t %s", $time, what);
    err_cnt++;
  endtask

  // Counter arithmetic wraps at the block width
  function automatic logic [127:0] plus_one(logic [127:0] v);
    return v + 128'd1;
  endfunction

  function automatic logic [127:0] rand_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // Inputs change a short delay after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #(drive_ns);
  endtask

  task automatic load_counter(logic [127:0] v);
    load     = 1'b1;
    ctr_data = v;
    next_cycle();
    load      = 1'b0;
    model_ctr = v;
  endtask

  task automatic request_increment();
    exp_ctr = plus_one(model_ctr);
    incr_mr = MUBI4_TRUE;
    next_cycle();
    incr_mr   = MUBI4_FALSE;
    model_ctr = exp_ctr;
  endtask

  // Extra cycle at the end lets the result check fire on the ready edge
  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready && n < ready_wait) begin
      next_cycle();
      n++;
    end
    if (!ready) begin
      log_failure("ready_o did not return high after an increment");
    end
    next_cycle();
  endtask

  task automatic reset_dut();
    rst_req = 1'b1;
    wait (!rst_n);
    rst_req = 1'b0;
    wait (rst_n);
    model_ctr = '0;
    next_cycle();
    next_cycle();
  endtask

  task automatic finish_test(string name, int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: pass", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Result is visible as soon as ready rises again
  result_a : assert property (
    @(posedge clk) disable iff (!rst_n || alert)
    $rose(ready) |-> ctr == exp_ctr
  ) else log_mismatch("ctr_o", exp_ctr, $sampled(ctr));

  // Accepted request keeps ready low for exactly 8 cycles
  busy_len_a : assert property (
    @(posedge clk) disable iff (!rst_n || alert)
    (ready && incr_mr == MUBI4_TRUE) |=> !ready [*8] ##1 ready
  ) else log_failure("ready_o busy time differs from 8 cycles after an accepted increment");

  // Invalid code or external error raises the alert on the next edge
  fault_alert_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (!(incr_mr inside {MUBI4_TRUE, MUBI4_FALSE}) || incr_err) |=> alert
  ) else log_mismatch("alert_o", 1, $sampled(alert));

  alert_sticky_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    alert |=> alert
  ) else log_mismatch("alert_o", 1, $sampled(alert));

  error_not_ready_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    alert |-> !ready
  ) else log_mismatch("ready_o", 0, $sampled(ready));

  // Counter frozen once in the error state
  ctr_frozen_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    alert |=> ctr == $past(ctr)
  ) else log_mismatch("ctr_o", $past(ctr), $sampled(ctr));

  // Clean state right after each reset
  reset_alert_a : assert property (
    @(posedge clk) $rose(rst_n) |-> !alert
  ) else log_mismatch("alert_o", 0, $sampled(alert));

  reset_ready_a : assert property (
    @(posedge clk) $rose(rst_n) |-> ready
  ) else log_mismatch("ready_o", 1, $sampled(ready));

  reset_ctr_a : assert property (
    @(posedge clk) $rose(rst_n) |-> ctr == '0
  ) else log_mismatch("ctr_o", 0, $sampled(ctr));

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int errs;
    int i;
    rst_req   = 1'b0;
    incr_mr   = MUBI4_FALSE;
    incr_err  = 1'b0;
    load      = 1'b0;
    ctr_data  = '0;
    model_ctr = '0;
    exp_ctr   = '0;
    @(posedge rst_n);
    next_cycle();

    // 1. Random value plus one
    errs = err_cnt;
    load_counter(rand_block());
    request_increment();
    wait_ready();
    finish_test("test 1 random increment", errs);

    // 2. Carry ripples through the all-ones low slices
    errs = err_cnt;
    load_counter(rand_block() | {16'h0, {112{1'b1}}});
    request_increment();
    wait_ready();
    load_counter(rand_block() | {64'h0, {64{1'b1}}});
    request_increment();
    wait_ready();
    finish_test("test 2 carry ripple", errs);

    // 3. All ones wraps to zero
    errs = err_cnt;
    load_counter({128{1'b1}});
    request_increment();
    wait_ready();
    finish_test("test 3 wrap-around", errs);

    // 4. Requests and loads while busy must be dropped
    errs = err_cnt;
    load_counter(rand_block());
    request_increment();
    next_cycle();
    incr_mr  = MUBI4_TRUE;
    load     = 1'b1;
    ctr_data = rand_block();
    for (i = 0; i < 3; i++) begin
      next_cycle();
    end
    incr_mr = MUBI4_FALSE;
    load    = 1'b0;
    wait_ready();
    finish_test("test 4 busy timing", errs);

    // 5. Invalid code 4'h0 while idle
    errs = err_cnt;
    load_counter(rand_block());
    incr_mr = mubi4_e'(4'h0);
    next_cycle();
    incr_mr = MUBI4_FALSE;
    load_counter(rand_block());
    incr_mr = MUBI4_TRUE;
    for (i = 0; i < 4; i++) begin
      next_cycle();
    end
    incr_mr = MUBI4_FALSE;
    if (!alert) begin
      log_failure("alert_o not raised by an invalid code");
    end
    reset_dut();
    finish_test("test 5 invalid code", errs);

    // 6. External error in the middle of an increment
    errs = err_cnt;
    load_counter(rand_block());
    request_increment();
    next_cycle();
    next_cycle();
    next_cycle();
    incr_err = 1'b1;
    next_cycle();
    incr_err = 1'b0;
    load_counter(rand_block());
    for (i = 0; i < 4; i++) begin
      next_cycle();
    end
    if (!alert) begin
      log_failure("alert_o not raised by incr_err_i");
    end
    reset_dut();
    finish_test("test 6 external error", errs);

    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Run length bound of 40 cycles per test on top of the power-on reset
  initial begin
    #((num_tests * 40 + rst_cycles) * period_ns);
    $display("Watchdog expired, tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+design
design/aes_ctr_pkg.sv
design/aes_ctr_mr_check.sv
design/aes_ctr_fsm.sv
design/aes_ctr_reg.sv
design/aes_ctr_top.sv
test/tb_clk_gen.sv
test/tb_aes_ctr_top.sv
